// ==== compile.f ====
rtl/rv_pkg.sv
rtl/rv_dec_exe_if.sv
rtl/rv_reg_file.sv
rtl/rv_decode.sv
rtl/rv_dec_exe_reg.sv
rtl/rv_alu.sv
rtl/rv_execute.sv
rtl/rv_core.sv
tests/tb_rv_core.sv

// ==== rtl/rv_alu.sv ====
module rv_alu (
    input  rv_pkg::alu_op_t op_i,
    input  rv_pkg::xlen_t   a_i,
    input  rv_pkg::xlen_t   b_i,
    output rv_pkg::xlen_t   result_o
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SRL:  result_o = a_i >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  result_o = xlen_t'($signed(a_i) >>> shamt);
            ALU_SLT:  result_o = xlen_t'($signed(a_i) < $signed(b_i));
            ALU_SLTU: result_o = xlen_t'(a_i < b_i);
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            default:  result_o = '0;
        endcase
    end

endmodule

// ==== rtl/rv_core.sv ====
module rv_core #(
    parameter int REG_ADDR_W = rv_pkg::REG_ADDR_W
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    output logic        wb_valid_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o
);
    import rv_pkg::*;

    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_rd;
    xlen_t                 wb_data;

    rv_dec_exe_if #(.REG_ADDR_W(REG_ADDR_W)) dec_if ();
    rv_dec_exe_if #(.REG_ADDR_W(REG_ADDR_W)) exe_if ();

    // ------------------------------------------------------------------
    // pipeline
    // ------------------------------------------------------------------
    rv_decode #(
        .REG_ADDR_W (REG_ADDR_W)
    ) i_decode (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_we_i      (wb_we),
        .wb_rd_i      (wb_rd),
        .wb_data_i    (wb_data),
        .dec_o        (dec_if.dec)
    );

    rv_dec_exe_reg #(
        .REG_ADDR_W (REG_ADDR_W)
    ) i_dec_exe_reg (
        .clk   (clk),
        .rst   (rst),
        .dec_i (dec_if.buf_in),
        .exe_o (exe_if.buf_out)
    );

    rv_execute #(
        .REG_ADDR_W (REG_ADDR_W)
    ) i_execute (
        .clk       (clk),
        .rst       (rst),
        .exe_i     (exe_if.exe),
        .wb_we_o   (wb_we),
        .wb_rd_o   (wb_rd),
        .wb_data_o (wb_data)
    );

    // register writes also leave the core
    assign wb_valid_o = wb_we;
    assign wb_rd_o    = 5'(wb_rd);
    assign wb_data_o  = wb_data;

endmodule

// ==== rtl/rv_dec_exe_if.sv ====
interface rv_dec_exe_if #(
    parameter int REG_ADDR_W = rv_pkg::REG_ADDR_W
);
    import rv_pkg::*;

    logic                  valid;
    alu_op_t               alu_op;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  rd_we;
    xlen_t                 rs1_data;
    xlen_t                 rs2_data;
    xlen_t                 imm;
    // immediate replaces rs2 as operand b
    logic                  b_imm;

    // decode side
    modport dec (
        output valid, alu_op, rs1_addr, rs2_addr, rd_addr, rd_we,
        output rs1_data, rs2_data, imm, b_imm
    );

    // pipeline register, reading decode
    modport buf_in (
        input valid, alu_op, rs1_addr, rs2_addr, rd_addr, rd_we,
        input rs1_data, rs2_data, imm, b_imm
    );

    // pipeline register, driving execute
    modport buf_out (
        output valid, alu_op, rs1_addr, rs2_addr, rd_addr, rd_we,
        output rs1_data, rs2_data, imm, b_imm
    );

    modport exe (
        input valid, alu_op, rs1_addr, rs2_addr, rd_addr, rd_we,
        input rs1_data, rs2_data, imm, b_imm
    );

endinterface

// ==== rtl/rv_dec_exe_reg.sv ====
module rv_dec_exe_reg #(
    parameter int REG_ADDR_W = rv_pkg::REG_ADDR_W
) (
    input  logic          clk,
    input  logic          rst,
    rv_dec_exe_if.buf_in  dec_i,
    rv_dec_exe_if.buf_out exe_o
);

    localparam logic [REG_ADDR_W-1:0] X0_ADDR = '0;

    // ------------------------------------------------------------------
    // control fields
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            exe_o.valid    <= 1'b0;
            exe_o.rd_we    <= 1'b0;
            exe_o.rs1_addr <= X0_ADDR;
            exe_o.rs2_addr <= X0_ADDR;
            exe_o.rd_addr  <= X0_ADDR;
        end else begin
            exe_o.valid    <= dec_i.valid;
            exe_o.rd_we    <= dec_i.rd_we;
            exe_o.rs1_addr <= dec_i.rs1_addr;
            exe_o.rs2_addr <= dec_i.rs2_addr;
            exe_o.rd_addr  <= dec_i.rd_addr;
        end
    end

    // operands and op select
    always_ff @(posedge clk) begin
        exe_o.alu_op   <= dec_i.alu_op;
        exe_o.rs1_data <= dec_i.rs1_data;
        exe_o.rs2_data <= dec_i.rs2_data;
        exe_o.imm      <= dec_i.imm;
        exe_o.b_imm    <= dec_i.b_imm;
    end

endmodule

// ==== rtl/rv_decode.sv ====
module rv_decode #(
    parameter int REG_ADDR_W = rv_pkg::REG_ADDR_W
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid_i,
    input  rv_pkg::inst_t         inst_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  rv_pkg::xlen_t         wb_data_i,
    rv_dec_exe_if.dec             dec_o
);
    import rv_pkg::*;

    opcode_t               opcode;
    logic [2:0]            funct3;
    logic                  funct7_b5;
    logic                  supported;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    xlen_t                 rs1_data;
    xlen_t                 rs2_data;

    // alt only matters for SUB and SRA
    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode    = opcode_t'(inst_i[6:0]);
    assign funct3    = inst_i[14:12];
    assign funct7_b5 = inst_i[30];
    assign rs2_addr  = inst_i[20 +: REG_ADDR_W];
    assign rd_addr   = inst_i[7 +: REG_ADDR_W];

    // ------------------------------------------------------------------
    // opcode decode and immediate select
    // ------------------------------------------------------------------
    always_comb begin
        supported     = 1'b1;
        rs1_addr      = inst_i[15 +: REG_ADDR_W];
        dec_o.alu_op  = ALU_ADD;
        dec_o.imm     = imm_i(inst_i);
        dec_o.b_imm   = 1'b1;
        case (opcode)
            OPC_REG: begin
                dec_o.b_imm  = 1'b0;
                dec_o.alu_op = alu_sel(funct3, funct7_b5);
            end
            // imm bit 30 is a plain immediate bit except on shift-right
            OPC_IMM: dec_o.alu_op = alu_sel(funct3, (funct3 == 3'b101) && funct7_b5);
            // lui becomes x0 + imm
            OPC_LUI: begin
                rs1_addr  = '0;
                dec_o.imm = imm_u(inst_i);
            end
            default: supported = 1'b0;
        endcase
    end

    assign dec_o.valid    = inst_valid_i;
    assign dec_o.rd_we    = inst_valid_i && supported && (rd_addr != '0);
    assign dec_o.rs1_addr = rs1_addr;
    assign dec_o.rs2_addr = rs2_addr;
    assign dec_o.rd_addr  = rd_addr;
    assign dec_o.rs1_data = rs1_data;
    assign dec_o.rs2_data = rs2_data;

    rv_reg_file #(
        .REG_ADDR_W (REG_ADDR_W)
    ) i_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .we_i       (wb_we_i),
        .rd_addr_i  (wb_rd_i),
        .rd_data_i  (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

endmodule

// ==== rtl/rv_execute.sv ====
module rv_execute #(
    parameter int REG_ADDR_W = rv_pkg::REG_ADDR_W
) (
    input  logic                  clk,
    input  logic                  rst,
    rv_dec_exe_if.exe             exe_i,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output rv_pkg::xlen_t         wb_data_o
);
    import rv_pkg::*;

    logic  fwd_rs1;
    logic  fwd_rs2;
    xlen_t op_a;
    xlen_t op_b;
    xlen_t alu_res;

    // ------------------------------------------------------------------
    // forwarding from the writeback register
    // ------------------------------------------------------------------
    assign fwd_rs1 = wb_we_o && (wb_rd_o != '0) && (wb_rd_o == exe_i.rs1_addr);
    assign fwd_rs2 = wb_we_o && (wb_rd_o != '0) && (wb_rd_o == exe_i.rs2_addr)
                     && !exe_i.b_imm;

    assign op_a = fwd_rs1 ? wb_data_o : exe_i.rs1_data;

    always_comb begin
        if (exe_i.b_imm) begin
            op_b = exe_i.imm;
        end else if (fwd_rs2) begin
            op_b = wb_data_o;
        end else begin
            op_b = exe_i.rs2_data;
        end
    end

    rv_alu i_alu (
        .op_i     (exe_i.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_res)
    );

    // ------------------------------------------------------------------
    // writeback register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= exe_i.valid && exe_i.rd_we;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= exe_i.rd_addr;
        wb_data_o <= alu_res;
    end

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0] inst_t;

    // ------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------

    // major opcodes handled by this datapath
    typedef enum logic [6:0] {
        OPC_REG = 7'b0110011,
        OPC_IMM = 7'b0010011,
        OPC_LUI = 7'b0110111
    } opcode_t;

    // low three bits follow funct3, bit 3 marks the alternate form
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_t;

    // ------------------------------------------------------------------
    // immediate helpers
    // ------------------------------------------------------------------

    // sign-extended I-type immediate
    function automatic xlen_t imm_i(input inst_t inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    // U-type immediate, low 12 bits zero
    function automatic xlen_t imm_u(input inst_t inst);
        return {inst[31:12], 12'b0};
    endfunction

endpackage

// ==== rtl/rv_reg_file.sv ====
module rv_reg_file #(
    parameter int REG_ADDR_W = rv_pkg::REG_ADDR_W
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  rv_pkg::xlen_t         rd_data_i,
    output rv_pkg::xlen_t         rs1_data_o,
    output rv_pkg::xlen_t         rs2_data_o
);
    import rv_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    xlen_t regs [NUM_REGS];

    // one read port, with write-through of the data being written
    function automatic xlen_t read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && (rd_addr_i == addr)) begin
            return rd_data_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
rm -f sim.log
verilator --binary --timing -f compile.f --top-module tb_rv_core -o tb_rv_core \
    && ./obj_dir/tb_rv_core > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TB PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/tb_rv_core.sv ====
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;

    // funct3 and funct7 bit 5 of the ten register-register operations
    localparam logic [2:0] R_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                         3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam logic R_ALT [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    // addi, slti, sltiu, xori, ori, andi
    localparam logic [2:0] I_F3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};

    localparam int TOTAL_INST = 62 + 40 + 20 + 8 + 4 + 40 + 3 + 31;
    localparam int WATCHDOG_NS = (TOTAL_INST + 40) * 8 * 2;

    typedef logic [31:0] reg_arr_t [32];

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        int unsigned cyc;
    } wb_exp_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    integer   seed = 32'he444391e;
    reg_arr_t model_regs;
    wb_exp_t  exp_q[$];
    int       cyc = 0;
    int       err_cnt = 0;
    int       check_cnt = 0;
    int       test_cnt = 0;
    logic     rst_q = 1'b0;
    logic     rst_qq = 1'b0;

    rv_core i_dut (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc    <= cyc + 1;
        rst_q  <= rst;
        rst_qq <= rst_q;
    end

    // ------------------------------------------------------------------
    // reference model and instruction encoders
    // ------------------------------------------------------------------
    function automatic logic expected_write(input logic [31:0] inst, input reg_arr_t regs,
                                            output logic [4:0] rd, output logic [31:0] data);
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic        alt;
        rd   = inst[11:7];
        f3   = inst[14:12];
        a    = regs[inst[19:15]];
        b    = regs[inst[24:20]];
        alt  = inst[30];
        data = '0;
        if (inst[6:0] == OP_LUI) begin
            data = {inst[31:12], 12'b0};
            return rd != 5'd0;
        end
        if (inst[6:0] == OP_IMM) begin
            b   = {{20{inst[31]}}, inst[31:20]};
            // bit 30 only picks srai among the immediate forms
            alt = inst[30] && (f3 == 3'd5);
        end else if (inst[6:0] != OP_REG) begin
            return 1'b0;
        end
        case (f3)
            3'd0:    data = alt ? a - b : a + b;
            3'd1:    data = a << b[4:0];
            3'd2:    data = {31'b0, $signed(a) < $signed(b)};
            3'd3:    data = {31'b0, a < b};
            3'd4:    data = a ^ b;
            3'd5:    data = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    data = a | b;
            default: data = a & b;
        endcase
        return rd != 5'd0;
    endfunction

    function automatic logic [31:0] r_inst(input logic alt, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_inst(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] lui_inst(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[4:0];
    endfunction

    // never x0
    function automatic logic [4:0] rand_rd();
        logic [31:0] r;
        r = $random(seed);
        return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
    endfunction

    // ------------------------------------------------------------------
    // stimulus and checking
    // ------------------------------------------------------------------
    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("error: %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic issue(input logic [31:0] inst);
        wb_exp_t     e;
        logic [4:0]  rd;
        logic [31:0] data;
        @(negedge clk);
        inst_i       = inst;
        inst_valid_i = 1'b1;
        if (expected_write(inst, model_regs, rd, data)) begin
            e.rd   = rd;
            e.data = data;
            // cycle in which the instruction is presented
            e.cyc  = cyc;
            exp_q.push_back(e);
            model_regs[rd] = data;
        end
    endtask

    // invalid cycle with garbage on the instruction bus
    task automatic idle_cycle();
        @(negedge clk);
        inst_valid_i = 1'b0;
        inst_i       = next_rand();
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst          = 1'b1;
        // a valid instruction stays on the bus for the whole reset
        inst_valid_i = 1'b1;
        inst_i       = i_inst(12'd1, 5'd0, 3'd0, 5'd3);
        repeat (16) @(negedge clk);
        rst          = 1'b0;
        inst_valid_i = 1'b0;
        // writes still in flight when reset hit are lost
        exp_q.delete();
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
    endtask

    task automatic finish_test(input string name);
        repeat (4) idle_cycle();
        if (exp_q.size() != 0) begin
            $display("%0t ns: %0d expected writebacks never arrived", $time, exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
        test_cnt++;
        $display("test %0d (%s) finished, errors so far: %0d", test_cnt, name, err_cnt);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        wb_exp_t e;
        if (rst_q || rst_qq) begin
            check_eq("wb_valid during reset", {31'b0, wb_valid_o}, 32'd0);
        end
        if (wb_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("%0t ns: unexpected writeback to x%0d", $time, wb_rd_o);
                err_cnt++;
            end else begin
                e = exp_q.pop_front();
                check_eq("wb rd", {27'b0, wb_rd_o}, {27'b0, e.rd});
                check_eq("wb data", wb_data_o, e.data);
                check_eq("wb cycle", cyc, e.cyc + 2);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        int          k;
        int          gap;
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        apply_reset();

        // seed every register, then all R-type ops
        for (int r = 1; r < 32; r++) begin
            rnd = next_rand();
            issue(lui_inst(rnd[31:12], 5'(r)));
            issue(i_inst(rnd[11:0], 5'(r), 3'd0, 5'(r)));
        end
        for (int op = 0; op < 10; op++) begin
            repeat (4) issue(r_inst(R_ALT[op], rand_reg(), rand_reg(), R_F3[op], rand_rd()));
        end
        finish_test("r-type");

        for (int n = 0; n < 20; n++) begin
            rnd = next_rand();
            k   = n % 10;
            if (k < 6) begin
                issue(i_inst(rnd[11:0] | 12'h800, rand_reg(), I_F3[k], rand_rd()));
            end else if (k == 6) begin
                issue(i_inst({7'b0, rnd[4:0]}, rand_reg(), 3'd1, rand_rd()));
            end else if (k == 7) begin
                issue(i_inst({7'b0, rnd[4:0]}, rand_reg(), 3'd5, rand_rd()));
            end else if (k == 8) begin
                issue(i_inst({7'b0100000, rnd[4:0]}, rand_reg(), 3'd5, rand_rd()));
            end else begin
                issue(lui_inst(rnd[31:12], rand_rd()));
            end
        end
        finish_test("i-type and lui");

        // distance 1 and 2 on both source operands
        issue(i_inst(12'd100, 5'd0, 3'd0, 5'd10));
        issue(i_inst(12'hffd, 5'd0, 3'd0, 5'd11));
        issue(r_inst(1'b0, 5'd11, 5'd10, 3'd0, 5'd12));
        issue(r_inst(1'b1, 5'd12, 5'd11, 3'd0, 5'd13));
        issue(r_inst(1'b0, 5'd12, 5'd13, 3'd4, 5'd14));
        issue(i_inst(12'd5, 5'd14, 3'd0, 5'd14));
        issue(r_inst(1'b0, 5'd14, 5'd13, 3'd6, 5'd15));
        issue(r_inst(1'b0, 5'd15, 5'd14, 3'd1, 5'd16));
        finish_test("dependent chains");

        // x0 write, then an unsupported load opcode aimed at x5
        issue(i_inst(12'd123, 5'd5, 3'd0, 5'd0));
        issue({12'd4, 5'd1, 3'b010, 5'd5, 7'b0000011});
        issue(r_inst(1'b0, 5'd0, 5'd0, 3'd0, 5'd8));
        issue(r_inst(1'b0, 5'd0, 5'd5, 3'd0, 5'd9));
        finish_test("x0 and unsupported");

        for (int n = 0; n < 40; n++) begin
            rnd = next_rand();
            gap = int'(rnd[9:8]);
            if (rnd[1:0] == 2'd1) begin
                issue(i_inst(rnd[31:20], rand_reg(), 3'd0, rand_rd()));
            end else if (rnd[1:0] == 2'd2) begin
                issue(lui_inst(rnd[31:12], rand_rd()));
            end else begin
                k = int'(rnd[7:4]) % 10;
                issue(r_inst(R_ALT[k], rand_reg(), rand_reg(), R_F3[k], rand_rd()));
            end
            repeat (gap) idle_cycle();
        end
        finish_test("random gaps");

        // reset lands on instructions still in the pipeline
        issue(i_inst(12'd77, 5'd0, 3'd0, 5'd20));
        issue(i_inst(12'd78, 5'd0, 3'd0, 5'd21));
        issue(i_inst(12'd79, 5'd0, 3'd0, 5'd22));
        apply_reset();
        for (int r = 1; r < 32; r++) begin
            issue(r_inst(1'b0, 5'd0, 5'(r), 3'd0, 5'(r)));
        end
        finish_test("mid-run reset");

        $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
